// File: Bender.yml
package:
  name: cfg_ctrl

sources:
  - source/cfg_ctrl_pkg.sv
  - source/wb_req_port.sv
  - source/aa_req_port.sv
  - source/req_arbiter.sv
  - source/axil_master.sv
  - source/target_router.sv
  - source/cfg_ctrl_top.sv
  - target: test
    files:
      - tests/cfg_ctrl_tb.sv

// File: all.f
source/cfg_ctrl_pkg.sv
source/wb_req_port.sv
source/aa_req_port.sv
source/req_arbiter.sv
source/axil_master.sv
source/target_router.sv
source/cfg_ctrl_top.sv
tests/cfg_ctrl_tb.sv

// File: source/aa_req_port.sv
`timescale 1ns/1ps
`default_nettype none

module aa_req_port import cfg_ctrl_pkg::*; (
	input  logic                  axi_clk,
	input  logic                  axi_reset_n,
	input  logic                  aa_awvalid_i,
	input  logic [REQ_ADDR_W-1:0] aa_awaddr_i,
	input  logic                  aa_wvalid_i,
	input  logic [DATA_W-1:0]     aa_wdata_i,
	input  logic [STRB_W-1:0]     aa_wstrb_i,
	input  logic                  aa_arvalid_i,
	input  logic [REQ_ADDR_W-1:0] aa_araddr_i,
	input  logic                  aa_rready_i,
	output logic                  aa_awready_o,
	output logic                  aa_wready_o,
	output logic                  aa_arready_o,
	output logic                  aa_rvalid_o,
	output logic [DATA_W-1:0]     aa_rdata_o,
	output logic                  req_o,
	output logic                  req_we_o,
	output logic [REQ_ADDR_W-1:0] req_addr_o,
	output logic [DATA_W-1:0]     req_wdata_o,
	output logic [STRB_W-1:0]     req_wstrb_o,
	input  logic                  done_i,
	input  logic [DATA_W-1:0]     rdata_i
);

	master_state_t state;
	logic          aw_take;
	logic          ar_take;
	logic          w_take;
	logic          r_done;

	assign aw_take = (state == MS_IDLE) && aa_awvalid_i;
	assign ar_take = (state == MS_IDLE) && !aa_awvalid_i && aa_arvalid_i;	// Write wins
	assign w_take  = (state == MS_WRITE_DATA) && aa_wvalid_i;
	// Read result is only taken while the FPGA side can accept it
	assign r_done  = (state == MS_READ_DATA) && aa_rready_i && done_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state        <= MS_IDLE;
			req_o        <= 1'b0;
			aa_awready_o <= 1'b0;
			aa_wready_o  <= 1'b0;
			aa_arready_o <= 1'b0;
			aa_rvalid_o  <= 1'b0;
		end else begin
			aa_awready_o <= aw_take;	// One cycle pulses
			aa_arready_o <= ar_take;
			aa_wready_o  <= (state == MS_WRITE_COMPLETE) && done_i;
			case (state)
				MS_IDLE: begin
					if (aw_take) begin
						state <= MS_WRITE_DATA;
					end else if (ar_take) begin
						req_o <= 1'b1;
						state <= MS_READ_DATA;
					end
				end
				MS_READ_DATA: begin
					if (r_done) begin
						aa_rvalid_o <= 1'b1;
						req_o       <= 1'b0;
						state       <= MS_READ_COMPLETE;
					end
				end
				MS_READ_COMPLETE: begin
					if (aa_rready_i) begin
						aa_rvalid_o <= 1'b0;
						state       <= MS_IDLE;
					end
				end
				MS_WRITE_DATA: begin
					if (w_take) begin
						req_o <= 1'b1;
						state <= MS_WRITE_COMPLETE;
					end
				end
				MS_WRITE_COMPLETE: begin
					if (done_i) begin
						req_o <= 1'b0;
						state <= MS_IDLE;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Request fields and read data
	////////////////////////////////////////
	always_ff @(posedge axi_clk) begin
		if (aw_take)
			req_addr_o <= aa_awaddr_i;
		else if (ar_take)
			req_addr_o <= aa_araddr_i;
		if (ar_take)
			req_we_o <= 1'b0;
		else if (w_take)
			req_we_o <= 1'b1;
		if (w_take) begin
			req_wdata_o <= aa_wdata_i;
			req_wstrb_o <= aa_wstrb_i;
		end
		if (r_done)
			aa_rdata_o <= rdata_i;
	end

endmodule

`default_nettype wire

// File: source/axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module axil_master import cfg_ctrl_pkg::*; #(
	parameter int M_ADDR_W = 15
) (
	input  logic                  axi_clk,
	input  logic                  axi_reset_n,
	input  logic                  m_req_i,
	input  logic                  m_we_i,
	input  logic [REQ_ADDR_W-1:0] m_addr_i,
	input  logic [DATA_W-1:0]     m_wdata_i,
	input  logic [STRB_W-1:0]     m_wstrb_i,
	output logic                  done_o,
	output logic [DATA_W-1:0]     rdata_o,
	output logic                  axi_awvalid_o,
	output logic [M_ADDR_W-1:0]   axi_awaddr_o,
	output logic                  axi_wvalid_o,
	output logic [DATA_W-1:0]     axi_wdata_o,
	output logic [STRB_W-1:0]     axi_wstrb_o,
	output logic                  axi_arvalid_o,
	output logic [M_ADDR_W-1:0]   axi_araddr_o,
	output logic                  axi_rready_o,
	input  logic                  s_awready_i,
	input  logic                  s_wready_i,
	input  logic                  s_arready_i,
	input  logic [DATA_W-1:0]     s_rdata_i,
	input  logic                  s_rvalid_i
);

	master_state_t       state;
	logic [M_ADDR_W-1:0] addr_q;
	logic                start;
	logic                wr_done;
	logic                rd_done;

	// A request still high right after its done pulse is the old one
	assign start = (state == MS_IDLE) && m_req_i && !done_o;

	// wready and rvalid count with the address phase or after it
	assign wr_done = s_wready_i &&
		((state == MS_WRITE_DATA && s_awready_i) || state == MS_WRITE_COMPLETE);
	assign rd_done = s_rvalid_i &&
		((state == MS_READ_DATA && s_arready_i) || state == MS_READ_COMPLETE);

	assign axi_awaddr_o = addr_q;
	assign axi_araddr_o = addr_q;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state         <= MS_IDLE;
			done_o        <= 1'b0;
			axi_awvalid_o <= 1'b0;
			axi_wvalid_o  <= 1'b0;
			axi_arvalid_o <= 1'b0;
			axi_rready_o  <= 1'b0;
		end else begin
			done_o <= wr_done || rd_done;
			case (state)
				MS_IDLE: begin
					if (start && m_we_i) begin
						axi_awvalid_o <= 1'b1;
						axi_wvalid_o  <= 1'b1;
						state         <= MS_WRITE_DATA;
					end else if (start) begin
						axi_arvalid_o <= 1'b1;
						axi_rready_o  <= 1'b1;
						state         <= MS_READ_DATA;
					end
				end
				MS_WRITE_DATA, MS_WRITE_COMPLETE: begin
					if (s_awready_i)
						axi_awvalid_o <= 1'b0;
					if (wr_done) begin
						axi_wvalid_o <= 1'b0;
						state        <= MS_IDLE;
					end else if (s_awready_i) begin
						state <= MS_WRITE_COMPLETE;	// Still waiting on wready
					end
				end
				MS_READ_DATA, MS_READ_COMPLETE: begin
					if (s_arready_i)
						axi_arvalid_o <= 1'b0;
					if (rd_done) begin
						axi_rready_o <= 1'b0;
						state        <= MS_IDLE;
					end else if (s_arready_i) begin
						state <= MS_READ_COMPLETE;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Bus payload
	////////////////////////////////////////
	always_ff @(posedge axi_clk) begin
		if (start) begin
			addr_q      <= m_addr_i[M_ADDR_W-1:0];	// Truncated onto the bus
			axi_wdata_o <= m_wdata_i;
			axi_wstrb_o <= m_wstrb_i;
		end
		if (rd_done)
			rdata_o <= s_rdata_i;
	end

endmodule

`default_nettype wire

// File: source/cfg_ctrl_pkg.sv
`default_nettype none

package cfg_ctrl_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////
	localparam int DATA_W      = 32;
	localparam int STRB_W      = 4;
	localparam int REQ_ADDR_W  = 32;
	localparam int PAGE_OFFS_W = 12;
	localparam int PAGE_W      = REQ_ADDR_W - PAGE_OFFS_W;	// 20 bits of page number

	// Width of the user project select register
	localparam int SEL_W = 5;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////
	localparam logic [PAGE_W-1:0] CFG_BASE_PAGE = 20'h30000;	// Target 0
	localparam logic [PAGE_W-1:0] CFG_LAST_PAGE = 20'h3FFFF;	// Top of config window

	// Spare pages answer reads with this
	localparam logic [DATA_W-1:0] SPARE_RDATA = 32'hFFFF_FFFF;

	////////////////////////////////////////
	// Shared FSM encoding
	////////////////////////////////////////
	typedef enum logic [2:0] {
		MS_IDLE           = 3'b000,
		MS_READ_DATA      = 3'b001,
		MS_READ_COMPLETE  = 3'b010,
		MS_WRITE_DATA     = 3'b011,
		MS_WRITE_COMPLETE = 3'b100
	} master_state_t;

endpackage

`default_nettype wire

// File: source/cfg_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_top import cfg_ctrl_pkg::*; #(
	parameter int N_TARGETS = 5,
	parameter int M_ADDR_W  = 15
) (
	input  logic                             axi_clk,
	input  logic                             axi_reset_n,
	// Wishbone slave
	input  logic [REQ_ADDR_W-1:0]            wbs_adr_i,
	input  logic [DATA_W-1:0]                wbs_wdata_i,
	input  logic [STRB_W-1:0]                wbs_sel_i,
	input  logic                             wbs_cyc_i,
	input  logic                             wbs_stb_i,
	input  logic                             wbs_we_i,
	output logic                             wbs_ack_o,
	output logic [DATA_W-1:0]                wbs_rdata_o,
	// FPGA side AXI-Lite slave
	input  logic                             aa_awvalid_i,
	input  logic [REQ_ADDR_W-1:0]            aa_awaddr_i,
	input  logic                             aa_wvalid_i,
	input  logic [DATA_W-1:0]                aa_wdata_i,
	input  logic [STRB_W-1:0]                aa_wstrb_i,
	input  logic                             aa_arvalid_i,
	input  logic [REQ_ADDR_W-1:0]            aa_araddr_i,
	input  logic                             aa_rready_i,
	output logic                             aa_awready_o,
	output logic                             aa_wready_o,
	output logic                             aa_arready_o,
	output logic                             aa_rvalid_o,
	output logic [DATA_W-1:0]                aa_rdata_o,
	// AXI-Lite master
	output logic                             axi_awvalid_o,
	output logic [M_ADDR_W-1:0]              axi_awaddr_o,
	output logic                             axi_wvalid_o,
	output logic [DATA_W-1:0]                axi_wdata_o,
	output logic [STRB_W-1:0]                axi_wstrb_o,
	output logic                             axi_arvalid_o,
	output logic [M_ADDR_W-1:0]              axi_araddr_o,
	output logic                             axi_rready_o,
	// Targets
	input  logic [N_TARGETS-1:0]             tgt_awready_i,
	input  logic [N_TARGETS-1:0]             tgt_wready_i,
	input  logic [N_TARGETS-1:0]             tgt_arready_i,
	input  logic [N_TARGETS-1:0]             tgt_rvalid_i,
	input  logic [N_TARGETS-1:0][DATA_W-1:0] tgt_rdata_i,
	output logic [N_TARGETS-1:0]             tgt_enable_o,
	output logic [SEL_W-1:0]                 user_prj_sel_o
);

	logic                  wb_req, wb_we, wb_done;
	logic [REQ_ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0]     wb_wdata, wb_rdata;
	logic [STRB_W-1:0]     wb_wstrb;
	logic                  aa_req, aa_we, aa_done;
	logic [REQ_ADDR_W-1:0] aa_addr;
	logic [DATA_W-1:0]     aa_wdata, aa_rdata;
	logic [STRB_W-1:0]     aa_wstrb;
	logic                  m_req, m_we, m_done;
	logic [REQ_ADDR_W-1:0] m_addr;
	logic [DATA_W-1:0]     m_wdata, m_rdata;
	logic [STRB_W-1:0]     m_wstrb;
	logic                  s_awready, s_wready, s_arready, s_rvalid;
	logic [DATA_W-1:0]     s_rdata;

	wb_req_port wb_req_port_i (
		.*,
		.req_o(wb_req), .req_we_o(wb_we), .req_addr_o(wb_addr),
		.req_wdata_o(wb_wdata), .req_wstrb_o(wb_wstrb),
		.done_i(wb_done), .rdata_i(wb_rdata)
	);

	aa_req_port aa_req_port_i (
		.*,
		.req_o(aa_req), .req_we_o(aa_we), .req_addr_o(aa_addr),
		.req_wdata_o(aa_wdata), .req_wstrb_o(aa_wstrb),
		.done_i(aa_done), .rdata_i(aa_rdata)
	);

	req_arbiter req_arbiter_i (
		.axi_clk, .axi_reset_n,
		.wb_req_i(wb_req), .wb_we_i(wb_we), .wb_addr_i(wb_addr),
		.wb_wdata_i(wb_wdata), .wb_wstrb_i(wb_wstrb),
		.aa_req_i(aa_req), .aa_we_i(aa_we), .aa_addr_i(aa_addr),
		.aa_wdata_i(aa_wdata), .aa_wstrb_i(aa_wstrb),
		.m_req_o(m_req), .m_we_o(m_we), .m_addr_o(m_addr),
		.m_wdata_o(m_wdata), .m_wstrb_o(m_wstrb),
		.m_done_i(m_done), .m_rdata_i(m_rdata),
		.wb_done_o(wb_done), .aa_done_o(aa_done),
		.wb_rdata_o(wb_rdata), .aa_rdata_o(aa_rdata)
	);

	axil_master #(.M_ADDR_W(M_ADDR_W)) axil_master_i (
		.*,
		.m_req_i(m_req), .m_we_i(m_we), .m_addr_i(m_addr),
		.m_wdata_i(m_wdata), .m_wstrb_i(m_wstrb),
		.done_o(m_done), .rdata_o(m_rdata),
		.s_awready_i(s_awready), .s_wready_i(s_wready), .s_arready_i(s_arready),
		.s_rdata_i(s_rdata), .s_rvalid_i(s_rvalid)
	);

	target_router #(.N_TARGETS(N_TARGETS)) target_router_i (
		.*,
		.req_addr_i(m_addr),
		.axi_awvalid_i(axi_awvalid_o),
		.axi_awaddr_i(axi_awaddr_o[PAGE_OFFS_W-1:0]),
		.axi_wvalid_i(axi_wvalid_o),
		.axi_wdata_i(axi_wdata_o),
		.axi_wstrb_i(axi_wstrb_o),
		.axi_arvalid_i(axi_arvalid_o),
		.s_awready_o(s_awready), .s_wready_o(s_wready), .s_arready_o(s_arready),
		.s_rdata_o(s_rdata), .s_rvalid_o(s_rvalid)
	);

endmodule

`default_nettype wire

// File: source/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import cfg_ctrl_pkg::*; (
	input  logic                  axi_clk,
	input  logic                  axi_reset_n,
	input  logic                  wb_req_i,
	input  logic                  wb_we_i,
	input  logic [REQ_ADDR_W-1:0] wb_addr_i,
	input  logic [DATA_W-1:0]     wb_wdata_i,
	input  logic [STRB_W-1:0]     wb_wstrb_i,
	input  logic                  aa_req_i,
	input  logic                  aa_we_i,
	input  logic [REQ_ADDR_W-1:0] aa_addr_i,
	input  logic [DATA_W-1:0]     aa_wdata_i,
	input  logic [STRB_W-1:0]     aa_wstrb_i,
	output logic                  m_req_o,
	output logic                  m_we_o,
	output logic [REQ_ADDR_W-1:0] m_addr_o,
	output logic [DATA_W-1:0]     m_wdata_o,
	output logic [STRB_W-1:0]     m_wstrb_o,
	input  logic                  m_done_i,
	input  logic [DATA_W-1:0]     m_rdata_i,
	output logic                  wb_done_o,
	output logic                  aa_done_o,
	output logic [DATA_W-1:0]     wb_rdata_o,
	output logic [DATA_W-1:0]     aa_rdata_o
);

	logic grant;	// 0 Wishbone, 1 FPGA side

	// Sticky grant, moves only once the owner has let go
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			grant <= 1'b0;
		else if (!grant && !wb_req_i && aa_req_i)
			grant <= 1'b1;
		else if (grant && !aa_req_i && wb_req_i)
			grant <= 1'b0;
	end

	assign m_req_o   = grant ? aa_req_i   : wb_req_i;
	assign m_we_o    = grant ? aa_we_i    : wb_we_i;
	assign m_addr_o  = grant ? aa_addr_i  : wb_addr_i;
	assign m_wdata_o = grant ? aa_wdata_i : wb_wdata_i;
	assign m_wstrb_o = grant ? aa_wstrb_i : wb_wstrb_i;

	// Completion goes back to the owner only
	assign wb_done_o  = m_done_i && !grant;
	assign aa_done_o  = m_done_i && grant;
	assign wb_rdata_o = grant ? '0 : m_rdata_i;
	assign aa_rdata_o = grant ? m_rdata_i : '0;

endmodule

`default_nettype wire

// File: source/target_router.sv
`timescale 1ns/1ps
`default_nettype none

module target_router import cfg_ctrl_pkg::*; #(
	parameter int N_TARGETS = 5
) (
	input  logic                             axi_clk,
	input  logic                             axi_reset_n,
	input  logic [REQ_ADDR_W-1:0]            req_addr_i,
	input  logic                             axi_awvalid_i,
	input  logic [PAGE_OFFS_W-1:0]           axi_awaddr_i,	// Offset within the page
	input  logic                             axi_wvalid_i,
	input  logic [DATA_W-1:0]                axi_wdata_i,
	input  logic [STRB_W-1:0]                axi_wstrb_i,
	input  logic                             axi_arvalid_i,
	input  logic [N_TARGETS-1:0]             tgt_awready_i,
	input  logic [N_TARGETS-1:0]             tgt_wready_i,
	input  logic [N_TARGETS-1:0]             tgt_arready_i,
	input  logic [N_TARGETS-1:0]             tgt_rvalid_i,
	input  logic [N_TARGETS-1:0][DATA_W-1:0] tgt_rdata_i,
	output logic [N_TARGETS-1:0]             tgt_enable_o,
	output logic [SEL_W-1:0]                 user_prj_sel_o,
	output logic                             s_awready_o,
	output logic                             s_wready_o,
	output logic                             s_arready_o,
	output logic [DATA_W-1:0]                s_rdata_o,
	output logic                             s_rvalid_o
);

	// Own register page sits right above the external targets
	localparam logic [PAGE_W-1:0] LOCAL_PAGE = CFG_BASE_PAGE + PAGE_W'(N_TARGETS);

	logic [PAGE_W-1:0] page;
	logic              local_en;
	logic              spare_en;
	logic              self_en;	// Answered inside the controller

	assign page    = req_addr_i[REQ_ADDR_W-1 -: PAGE_W];
	assign self_en = local_en || spare_en;

	////////////////////////////////////////
	// Registered page decode
	////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			tgt_enable_o <= '0;
			local_en     <= 1'b0;
			spare_en     <= 1'b0;
		end else begin
			for (int k = 0; k < N_TARGETS; k++) begin
				tgt_enable_o[k] <= (page == CFG_BASE_PAGE + PAGE_W'(k));
			end
			local_en <= (page == LOCAL_PAGE);
			spare_en <= (page > LOCAL_PAGE) && (page <= CFG_LAST_PAGE);
		end
	end

	// Return path, OR of whatever source is enabled
	always_comb begin
		s_awready_o = self_en && axi_awvalid_i;	// Local and spare echo the valids
		s_wready_o  = self_en && axi_wvalid_i;
		s_arready_o = self_en && axi_arvalid_i;
		s_rvalid_o  = self_en && axi_arvalid_i;
		s_rdata_o   = '0;
		if (local_en)
			s_rdata_o = DATA_W'(user_prj_sel_o);
		if (spare_en)
			s_rdata_o = SPARE_RDATA;
		for (int k = 0; k < N_TARGETS; k++) begin
			s_awready_o = s_awready_o || (tgt_enable_o[k] && tgt_awready_i[k]);
			s_wready_o  = s_wready_o  || (tgt_enable_o[k] && tgt_wready_i[k]);
			s_arready_o = s_arready_o || (tgt_enable_o[k] && tgt_arready_i[k]);
			s_rvalid_o  = s_rvalid_o  || (tgt_enable_o[k] && tgt_rvalid_i[k]);
			s_rdata_o   = s_rdata_o | ({DATA_W{tgt_enable_o[k]}} & tgt_rdata_i[k]);
		end
	end

	// User project select, offset 0 of the local page
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			user_prj_sel_o <= '0;
		else if (local_en && axi_awvalid_i && axi_wvalid_i &&
				axi_awaddr_i == '0 && axi_wstrb_i[0])
			user_prj_sel_o <= axi_wdata_i[SEL_W-1:0];
	end

endmodule

`default_nettype wire

// File: source/wb_req_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_req_port import cfg_ctrl_pkg::*; (
	input  logic                  axi_clk,
	input  logic                  axi_reset_n,
	input  logic [REQ_ADDR_W-1:0] wbs_adr_i,
	input  logic [DATA_W-1:0]     wbs_wdata_i,
	input  logic [STRB_W-1:0]     wbs_sel_i,
	input  logic                  wbs_cyc_i,
	input  logic                  wbs_stb_i,
	input  logic                  wbs_we_i,
	output logic                  wbs_ack_o,
	output logic [DATA_W-1:0]     wbs_rdata_o,
	output logic                  req_o,
	output logic                  req_we_o,
	output logic [REQ_ADDR_W-1:0] req_addr_o,
	output logic [DATA_W-1:0]     req_wdata_o,
	output logic [STRB_W-1:0]     req_wstrb_o,
	input  logic                  done_i,
	input  logic [DATA_W-1:0]     rdata_i
);

	typedef enum logic {
		WB_IDLE,
		WB_BUSY
	} wb_state_t;

	wb_state_t state;
	logic      take;	// Cycle accepted on this edge

	// No new cycle while the ack of the previous one is still out
	assign take = (state == WB_IDLE) && !wbs_ack_o && wbs_cyc_i && wbs_stb_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state     <= WB_IDLE;
			req_o     <= 1'b0;
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= 1'b0;	// Single cycle ack
			if (take) begin
				req_o <= 1'b1;
				state <= WB_BUSY;
			end else if (state == WB_BUSY && done_i) begin
				wbs_ack_o <= 1'b1;
				req_o     <= 1'b0;
				state     <= WB_IDLE;
			end
		end
	end

	// Latched request fields and returned read data
	always_ff @(posedge axi_clk) begin
		if (take) begin
			req_we_o    <= wbs_we_i;
			req_addr_o  <= wbs_adr_i;
			req_wdata_o <= wbs_wdata_i;
			req_wstrb_o <= wbs_sel_i;
		end
		if (state == WB_BUSY && done_i && !req_we_o)
			wbs_rdata_o <= rdata_i;
	end

endmodule

`default_nettype wire

// File: tests/cfg_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_tb;

	localparam int NT        = 5;
	localparam int ROWS      = 19;
	localparam int MAX_CYC   = ROWS * 40 + 20;
	localparam int PORT_WB   = 0;
	localparam int PORT_AA   = 1;
	localparam int PORT_BOTH = 2;
	localparam logic [19:0] BASE_PAGE = 20'h30000;

	logic                     axi_clk;
	logic                     axi_reset_n;
	logic [31:0]              wbs_adr_i, wbs_wdata_i, wbs_rdata_o;
	logic [3:0]               wbs_sel_i;
	logic                     wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
	logic                     aa_awvalid_i, aa_wvalid_i, aa_arvalid_i, aa_rready_i;
	logic [31:0]              aa_awaddr_i, aa_araddr_i, aa_wdata_i, aa_rdata_o;
	logic [3:0]               aa_wstrb_i;
	logic                     aa_awready_o, aa_wready_o, aa_arready_o, aa_rvalid_o;
	logic                     axi_awvalid_o, axi_wvalid_o, axi_arvalid_o, axi_rready_o;
	logic [14:0]              axi_awaddr_o, axi_araddr_o;
	logic [31:0]              axi_wdata_o;
	logic [3:0]               axi_wstrb_o;
	logic [NT-1:0]            tgt_awready_i, tgt_wready_i, tgt_arready_i, tgt_rvalid_i;
	logic [NT-1:0][31:0]      tgt_rdata_i;
	logic [NT-1:0]            tgt_enable_o;
	logic [4:0]               user_prj_sel_o;

	// Stimulus table, one entry per row
	int          row_port  [ROWS];
	logic        row_we    [ROWS];
	logic [31:0] row_addr  [ROWS];
	logic [31:0] row_wdata [ROWS];
	logic [3:0]  row_strb  [ROWS];
	logic [31:0] row_exp   [ROWS];
	logic [31:0] row_addr2 [ROWS];	// FPGA side read when both ports run
	logic [31:0] row_exp2  [ROWS];
	logic [4:0]  row_sel   [ROWS];

	logic [14:0]   seen_awaddr;
	logic [14:0]   seen_araddr;
	logic [31:0]   seen_wdata;
	logic [3:0]    seen_wstrb;
	logic [NT-1:0] seen_enable;
	int            seen_aw = 0;
	int            seen_w = 0;
	int            seen_ar = 0;
	int            seen_r = 0;
	int            cycles = 0;
	logic [31:0]   rdata, rdata2;

	cfg_ctrl_top cfg_ctrl_top_i (.*);

	initial axi_clk = 1'b0;
	always #4 axi_clk = ~axi_clk;

	////////////////////////////////////////
	// Target models
	////////////////////////////////////////
	assign tgt_awready_i = tgt_enable_o;	// Always ready once selected
	assign tgt_wready_i  = tgt_enable_o;
	assign tgt_arready_i = tgt_enable_o;
	assign tgt_rvalid_i  = tgt_enable_o;

	for (genvar k = 0; k < NT; k++) begin : g_tgt
		assign tgt_rdata_i[k] = 32'hA500_0000 + k;
	end

	// Handshakes taken by an external target
	always @(negedge axi_clk) begin
		if (axi_reset_n && axi_awvalid_o && |(tgt_enable_o & tgt_awready_i)) begin
			seen_awaddr = axi_awaddr_o;
			seen_enable = tgt_enable_o;
			seen_aw++;
		end
		if (axi_reset_n && axi_wvalid_o && |(tgt_enable_o & tgt_wready_i)) begin
			seen_wdata = axi_wdata_o;
			seen_wstrb = axi_wstrb_o;
			seen_w++;
		end
		if (axi_reset_n && axi_arvalid_o && |(tgt_enable_o & tgt_arready_i)) begin
			seen_araddr = axi_araddr_o;
			seen_enable = tgt_enable_o;
			seen_ar++;
		end
		if (axi_reset_n && axi_rready_o && |(tgt_enable_o & tgt_rvalid_i))
			seen_r++;
	end

	always @(posedge axi_clk) begin
		cycles++;
		if (cycles >= MAX_CYC) begin
			$display("Timeout: tests still running after %0d cycles", MAX_CYC);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] tgt_pattern(input int k);
		return 32'hA500_0000 + k;
	endfunction

	function automatic logic [31:0] page_addr(input logic [19:0] page_idx,
			input logic [11:0] offs);
		return {BASE_PAGE + page_idx, offs};
	endfunction

	// External target index of an address, -1 for local and spare pages
	function automatic int target_of(input logic [31:0] addr);
		if (addr[31:12] >= BASE_PAGE && addr[31:12] < BASE_PAGE + NT)
			return int'(addr[31:12] - BASE_PAGE);
		return -1;
	endfunction

	task automatic add_row(input int idx, input int port, input logic we,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb,
			input logic [31:0] exp, input logic [31:0] addr2, input logic [31:0] exp2,
			input logic [4:0] sel);
		row_port[idx]  = port;
		row_we[idx]    = we;
		row_addr[idx]  = addr;
		row_wdata[idx] = wdata;
		row_strb[idx]  = strb;
		row_exp[idx]   = exp;
		row_addr2[idx] = addr2;
		row_exp2[idx]  = exp2;
		row_sel[idx]   = sel;
	endtask

	////////////////////////////////////////
	// Bus drivers
	////////////////////////////////////////
	task automatic wb_transfer(input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel,
			output logic [31:0] data);
		@(negedge axi_clk);
		wbs_cyc_i   = 1'b1;
		wbs_stb_i   = 1'b1;
		wbs_we_i    = we;
		wbs_adr_i   = addr;
		wbs_wdata_i = wdata;
		wbs_sel_i   = sel;
		@(negedge axi_clk);
		while (!wbs_ack_o)
			@(negedge axi_clk);
		data      = wbs_rdata_o;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	task automatic aa_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb);
		@(negedge axi_clk);
		aa_awvalid_i = 1'b1;
		aa_awaddr_i  = addr;
		aa_wvalid_i  = 1'b1;	// Data offered with the address
		aa_wdata_i   = wdata;
		aa_wstrb_i   = strb;
		@(negedge axi_clk);
		while (!aa_awready_o)
			@(negedge axi_clk);
		aa_awvalid_i = 1'b0;
		while (!aa_wready_o)
			@(negedge axi_clk);
		aa_wvalid_i = 1'b0;
	endtask

	task automatic aa_read(input logic [31:0] addr, output logic [31:0] data);
		@(negedge axi_clk);
		aa_arvalid_i = 1'b1;
		aa_araddr_i  = addr;
		aa_rready_i  = 1'b1;
		@(negedge axi_clk);
		while (!aa_arready_o)
			@(negedge axi_clk);
		aa_arvalid_i = 1'b0;
		while (!aa_rvalid_o)
			@(negedge axi_clk);
		data = aa_rdata_o;
		@(negedge axi_clk);	// rvalid handshake completes on this edge
		aa_rready_i = 1'b0;
	endtask

	initial begin
		int k;
		int aw_before;
		int w_before;
		int ar_before;
		int r_before;

		axi_reset_n  = 1'b0;
		wbs_adr_i    = '0;
		wbs_wdata_i  = '0;
		wbs_sel_i    = '0;
		wbs_cyc_i    = 1'b0;
		wbs_stb_i    = 1'b0;
		wbs_we_i     = 1'b0;
		aa_awvalid_i = 1'b0;
		aa_awaddr_i  = '0;
		aa_wvalid_i  = 1'b0;
		aa_wdata_i   = '0;
		aa_wstrb_i   = '0;
		aa_arvalid_i = 1'b0;
		aa_araddr_i  = '0;
		aa_rready_i  = 1'b0;

		// Reads of every external target
		for (int t = 0; t < NT; t++)
			add_row(t, PORT_WB, 0, page_addr(t, 12'h010 * t), 0, 4'hF, tgt_pattern(t),
				0, 0, 5'h00);
		add_row(5, PORT_AA, 1, page_addr(2, 12'hABC), 32'hDEAD_BEEF, 4'hF, 0, 0, 0, 5'h00);
		add_row(6, PORT_AA, 1, page_addr(4, 12'h008), 32'h1234_5678, 4'h3, 0, 0, 0, 5'h00);
		// Local select register
		add_row(7, PORT_WB, 1, page_addr(5, 12'h000), 32'h0000_0013, 4'h1, 0, 0, 0, 5'h13);
		add_row(8, PORT_AA, 0, page_addr(5, 12'h000), 0, 4'hF, 32'h13, 0, 0, 5'h13);
		add_row(9, PORT_WB, 0, page_addr(5, 12'h008), 0, 4'hF, 32'h13, 0, 0, 5'h13);
		add_row(10, PORT_AA, 1, page_addr(5, 12'h000), 32'h0000_000A, 4'hE, 0, 0, 0, 5'h13);
		add_row(11, PORT_AA, 1, page_addr(5, 12'h000), 32'hFFFF_FF2A, 4'h1, 0, 0, 0, 5'h0A);
		add_row(12, PORT_WB, 0, page_addr(5, 12'h000), 0, 4'hF, 32'h0A, 0, 0, 5'h0A);
		// Spare pages
		add_row(13, PORT_AA, 0, page_addr(20'h10, 0), 0, 4'hF, 32'hFFFF_FFFF, 0, 0, 5'h0A);
		add_row(14, PORT_WB, 1, page_addr(20'hFFFF, 0), 32'h1F, 4'hF, 0, 0, 0, 5'h0A);
		add_row(15, PORT_WB, 0, page_addr(20'hFFFF, 4), 0, 4'hF, 32'hFFFF_FFFF, 0, 0, 5'h0A);
		// Both ports at once
		add_row(16, PORT_BOTH, 0, page_addr(1, 0), 0, 4'hF, tgt_pattern(1),
			page_addr(3, 0), tgt_pattern(3), 5'h0A);
		add_row(17, PORT_BOTH, 0, page_addr(0, 4), 0, 4'hF, tgt_pattern(0),
			page_addr(5, 0), 32'h0A, 5'h0A);
		add_row(18, PORT_BOTH, 0, page_addr(5, 12'h010), 0, 4'hF, 32'h0A,
			page_addr(4, 8), tgt_pattern(4), 5'h0A);

		repeat (3) @(negedge axi_clk);
		axi_reset_n = 1'b1;

		for (int i = 0; i < ROWS; i++) begin
			aw_before = seen_aw;
			w_before  = seen_w;
			ar_before = seen_ar;
			r_before  = seen_r;
			k = target_of(row_addr[i]);
			case (row_port[i])
				PORT_WB:
					wb_transfer(row_we[i], row_addr[i], row_wdata[i], row_strb[i], rdata);
				PORT_AA: begin
					if (row_we[i])
						aa_write(row_addr[i], row_wdata[i], row_strb[i]);
					else
						aa_read(row_addr[i], rdata);
				end
				default: begin
					fork
						wb_transfer(1'b0, row_addr[i], '0, 4'hF, rdata);
						aa_read(row_addr2[i], rdata2);
					join
				end
			endcase

			if (row_port[i] == PORT_BOTH) begin
				check_value("wbs_rdata_o", rdata, row_exp[i]);
				check_value("aa_rdata_o", rdata2, row_exp2[i]);
			end else begin
				if (!row_we[i])
					check_value(row_port[i] == PORT_WB ? "wbs_rdata_o" : "aa_rdata_o",
						rdata, row_exp[i]);
				if (k >= 0 && row_we[i]) begin
					check_value("write address handshakes", seen_aw, aw_before + 1);
					check_value("write data handshakes", seen_w, w_before + 1);
					check_value("tgt_enable_o", seen_enable, 32'd1 << k);
					check_value("axi_awaddr_o", seen_awaddr, row_addr[i] & 32'h7FFF);
					check_value("axi_wdata_o", seen_wdata, row_wdata[i]);
					check_value("axi_wstrb_o", seen_wstrb, row_strb[i]);
				end else if (k >= 0) begin
					check_value("read address handshakes", seen_ar, ar_before + 1);
					check_value("read data handshakes", seen_r, r_before + 1);
					check_value("tgt_enable_o", seen_enable, 32'd1 << k);
					check_value("axi_araddr_o", seen_araddr, row_addr[i] & 32'h7FFF);
				end else begin
					check_value("external target handshakes",
						seen_aw + seen_w + seen_ar + seen_r,
						aw_before + w_before + ar_before + r_before);
				end
			end
			check_value("user_prj_sel_o", user_prj_sel_o, row_sel[i]);
		end

		@(negedge axi_clk);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
